//--- Makefile
SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv) verilog.f

obj_dir/Veg_tb: $(SRCS)
	verilator --binary --timing --top-module eg_tb -f verilog.f -o Veg_tb

run: obj_dir/Veg_tb
	@out="$$(./obj_dir/Veg_tb)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- src/eg_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "eg_params.svh"

// global envelope counter
// one step every EG_CNT_DIV rounds of all slots
module eg_counter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clk_en,
	input  logic                 zero,   // slot 0 marker
	output logic [`EG_CNT_W-1:0] eg_cnt
);

	localparam int BASE_W = $clog2(`EG_CNT_DIV);

	logic [BASE_W-1:0] base_cnt; // rounds since last step

	always_ff @(posedge clk) begin
		if (rst) begin
			base_cnt <= '0;
			eg_cnt   <= '0;
		end else if (clk_en && zero) begin
			if (base_cnt == BASE_W'(`EG_CNT_DIV - 1)) begin
				base_cnt <= '0;
				eg_cnt   <= eg_cnt + 1'b1; // free running, wraps
			end else begin
				base_cnt <= base_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/eg_level.sv
`timescale 1ns/1ps
`default_nettype none

`include "eg_params.svh"

// level update, then total level add
module eg_level import eg_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             clk_en,
	input  eg_step_t         step_in,
	output eg_phase_e        next_phase,
	output logic [`EG_W-1:0] next_level,
	output logic [`EG_W-1:0] eg_out
);

	eg_slot_t         s;
	logic [5:0]       rate;
	logic [8:0]       ar_base;
	logic [`EG_W-1:0] ar_sum;
	logic [`EG_W-1:0] ar_lvl;
	logic [3:0]       inc;
	logic [`EG_W:0]   dec_sum;
	logic [`EG_W-1:0] lvl;
	logic [`EG_W-1:0] lvl_q;
	eg_phase_e        phase_q;
	logic [6:0]       tl_q;
	logic [`EG_W:0]   tl_sum;

	assign s    = step_in.slot;
	assign rate = step_in.rate;

	////////////////////////////////////////////////////////////////////////////
	// stage one, attack is exponential, decay linear

	always_comb begin
		case (rate[5:2])
			4'b1101:          ar_base = {2'b00, s.level[`EG_W-1:3]} + 9'd1;
			4'b1110, 4'b1111: ar_base = {1'b0, s.level[`EG_W-1:2]} + 9'd1;
			default:          ar_base = {3'b000, s.level[`EG_W-1:4]} + 9'd1;
		endcase
		if (rate[5:4] == 2'b11)
			ar_sum = step_in.step ? {ar_base, 1'b0} : {1'b0, ar_base}; // double at top
		else
			ar_sum = step_in.step ? {1'b0, ar_base} : '0;
		ar_lvl = (ar_sum < s.level) ? s.level - ar_sum : '0; // floor at 0
	end

	// decay increment, 1 to 8 per step
	always_comb begin
		case (rate[5:2])
			4'b1100: inc = {2'b00, step_in.step, ~step_in.step};
			4'b1101: inc = {1'b0, step_in.step, ~step_in.step, 1'b0};
			4'b1110: inc = {step_in.step, ~step_in.step, 2'b00};
			4'b1111: inc = 4'd8;
			default: inc = {2'b00, step_in.step, 1'b0};
		endcase
		dec_sum = {1'b0, s.level} + {7'd0, inc};
	end

	always_comb begin
		if (s.ar_off)
			lvl = '0;
		else if (s.phase == ph_attack) begin
			if (step_in.sum_up && s.level != '0)
				lvl = (rate[5:1] == 5'h1f) ? '0 : ar_lvl; // 62,63 go straight to 0
			else
				lvl = s.level;
		end else if (step_in.sum_up)
			lvl = dec_sum[`EG_W] ? `EG_MAX : dec_sum[`EG_W-1:0];
		else
			lvl = s.level;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lvl_q   <= `EG_MAX;
			phase_q <= ph_release;
			tl_q    <= '0;
		end else if (clk_en) begin
			lvl_q   <= lvl;
			phase_q <= s.phase;
			tl_q    <= s.tl;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage two, add tl and clamp

	assign tl_sum = {1'b0, lvl_q} + {1'b0, tl_q, 3'b000}; // tl lsb is 8 level lsb

	always_ff @(posedge clk) begin
		if (rst) begin
			eg_out     <= `EG_MAX;
			next_level <= `EG_MAX;
			next_phase <= ph_release;
		end else if (clk_en) begin
			eg_out     <= tl_sum[`EG_W] ? `EG_MAX : tl_sum[`EG_W-1:0];
			next_level <= lvl_q;   // tl stays out of the loop
			next_phase <= phase_q;
		end
	end

endmodule

`default_nettype wire

//--- src/eg_params.svh
`ifndef EG_PARAMS_SVH
`define EG_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// envelope generator constants
////////////////////////////////////////////////////////////////////////////

// operator slots served per round
`define EG_SLOTS 24

// attenuation level, 1 lsb is about 0.09 dB
`define EG_W 10
`define EG_MAX 10'h3FF // silence

// global envelope counter
`define EG_CNT_W 15
`define EG_CNT_DIV 3 // rounds per counter step

// effective rate after key scaling
`define EG_RATE_W 6

`endif

//--- src/eg_phase.sv
`timescale 1ns/1ps
`default_nettype none

`include "eg_params.svh"

// key edge detection and phase FSM
// also picks the base rate for the chosen phase
module eg_phase import eg_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             clk_en,
	input  eg_cfg_t          cfg,
	input  logic             keyon_last,  // same slot one round ago
	input  eg_phase_e        prev_phase,
	input  logic [`EG_W-1:0] prev_level,
	output eg_slot_t         slot
);

	logic     keyon_now;
	logic     keyoff_now;
	logic [4:0] sus_lvl;
	eg_slot_t nxt;

	assign keyon_now  = cfg.keyon & ~keyon_last;
	assign keyoff_now = ~cfg.keyon & keyon_last;

	// sustain threshold vs top five level bits
	assign sus_lvl = (cfg.d1l == 4'd15) ? 5'd31 : {1'b0, cfg.d1l}; // 15 means bottom

	always_comb begin
		nxt.phase     = prev_phase;
		nxt.level     = prev_level;
		nxt.base_rate = cfg.rate2;
		nxt.ar_off    = 1'b0;
		nxt.ks        = cfg.ks;
		nxt.keycode   = cfg.keycode;
		nxt.tl        = cfg.tl;
		if (keyoff_now) begin
			nxt.phase     = ph_release;
			nxt.base_rate = {cfg.rrate, 1'b1}; // 4-bit rate scaled up
		end else if (keyon_now) begin
			nxt.phase     = ph_attack;
			nxt.base_rate = cfg.arate;
			nxt.ar_off    = (cfg.arate == 5'd31); // jump straight to 0
		end else begin
			case (prev_phase)
				ph_attack: begin
					if (prev_level == '0) begin
						nxt.phase     = ph_decay1;
						nxt.base_rate = cfg.rate1;
					end else begin
						nxt.base_rate = cfg.arate;
					end
				end
				ph_decay1: begin
					if (prev_level[`EG_W-1:`EG_W-5] >= sus_lvl) begin
						nxt.phase     = ph_decay2;
						nxt.base_rate = cfg.rate2;
					end else begin
						nxt.base_rate = cfg.rate1;
					end
				end
				ph_decay2:  nxt.base_rate = cfg.rate2;
				ph_release: nxt.base_rate = {cfg.rrate, 1'b1};
				default:    nxt.base_rate = cfg.rate2;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			slot <= SLOT_IDLE;
		else if (clk_en)
			slot <= nxt;
	end

endmodule

`default_nettype wire

//--- src/eg_pkg.sv
`default_nettype none

`include "eg_params.svh"

package eg_pkg;

	typedef enum logic [1:0] {
		ph_attack  = 2'd0,
		ph_decay1  = 2'd1,
		ph_decay2  = 2'd2,
		ph_release = 2'd3
	} eg_phase_e;

	// one slot's register settings, all valid in the same cycle
	typedef struct packed {
		logic [4:0] arate;   // attack rate
		logic [4:0] rate1;   // first decay rate
		logic [4:0] rate2;   // second decay rate
		logic [3:0] rrate;   // release rate
		logic [3:0] d1l;     // sustain level
		logic [1:0] ks;      // key scale
		logic [4:0] keycode;
		logic [6:0] tl;      // total level
		logic       keyon;
		logic [7:0] spare;   // reserved, kept zero
	} eg_cfg_t;

	// slot travelling from phase stage to level stage
	typedef struct packed {
		eg_phase_e           phase;
		logic [`EG_W-1:0]    level;
		logic [4:0]          base_rate;
		logic                ar_off;  // instant attack
		logic [1:0]          ks;
		logic [4:0]          keycode;
		logic [6:0]          tl;
	} eg_slot_t;

	typedef struct packed {
		eg_slot_t               slot;
		logic [`EG_RATE_W-1:0]  rate;
		logic                   step;
		logic                   sum_up; // counter bit toggled since last round
	} eg_step_t;

	// phase and level sent back around the slot loop
	typedef struct packed {
		eg_phase_e           phase;
		logic [`EG_W-1:0]    level;
	} eg_rec_t;

	// idle slot left in the pipeline by reset
	parameter eg_slot_t SLOT_IDLE = '{
		phase: ph_release, level: `EG_MAX, base_rate: 5'd0, ar_off: 1'b0,
		ks: 2'd0, keycode: 5'd0, tl: 7'd0
	};

endpackage

`default_nettype wire

//--- src/eg_rate.sv
`timescale 1ns/1ps
`default_nettype none

`include "eg_params.svh"

// key scaled rate, counter window and step pattern
module eg_rate import eg_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clk_en,
	input  eg_slot_t             slot,
	input  logic [`EG_CNT_W-1:0] eg_cnt,
	input  logic                 cnt_last,  // window lsb one round ago
	output eg_step_t             step_out,
	output logic                 cnt_bit
);

	logic [4:0]            ks_add;
	logic [`EG_RATE_W:0]   pre_rate;  // one extra bit for overflow
	logic [`EG_RATE_W-1:0] eff_rate;
	eg_slot_t              slot_q;
	logic [`EG_RATE_W-1:0] rate_q;
	logic                  attack;
	logic [3:0]            shamt;
	logic [2:0]            cnt_win;
	logic [7:0]            pattern;
	logic                  step;

	////////////////////////////////////////////////////////////////////////////
	// stage one, key scaling

	assign ks_add   = slot.keycode >> (2'd3 - slot.ks); // ks 3 adds the full keycode
	assign pre_rate = (slot.base_rate == 5'd0) ? '0 :
		{1'b0, slot.base_rate, 1'b0} + {2'b00, ks_add};
	assign eff_rate = pre_rate[`EG_RATE_W] ? '1 : pre_rate[`EG_RATE_W-1:0]; // cap at 63

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_q <= SLOT_IDLE;
			rate_q <= '0;
		end else if (clk_en) begin
			slot_q <= slot;
			rate_q <= eff_rate;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage two, counter window and pattern lookup

	assign attack = (slot_q.phase == ph_attack);

	// faster rates look at lower counter bits, attack one bit lower still
	always_comb begin
		if (attack)
			shamt = (rate_q[5:2] >= 4'd11) ? 4'd0 : 4'd11 - rate_q[5:2];
		else
			shamt = (rate_q[5:2] >= 4'd12) ? 4'd0 : 4'd12 - rate_q[5:2];
		cnt_win = 3'(eg_cnt >> shamt);
	end

	always_comb begin
		if (rate_q[5:4] == 2'b11) begin
			if (rate_q[5:2] == 4'hf && attack)
				pattern = 8'b11111111; // fastest attack
			else
				case (rate_q[1:0])
					2'd0: pattern = 8'b00000000;
					2'd1: pattern = 8'b10001000;
					2'd2: pattern = 8'b10101010;
					default: pattern = 8'b11101110;
				endcase
		end else if (rate_q[5:2] == 4'd0 && !attack) begin
			pattern = 8'b11111110; // slowest decay floor
		end else begin
			case (rate_q[1:0])
				2'd0: pattern = 8'b10101010;
				2'd1: pattern = 8'b11101010;
				2'd2: pattern = 8'b11101110;
				default: pattern = 8'b11111110;
			endcase
		end
	end

	assign step    = (rate_q[5:1] == 5'd0) ? 1'b0 : pattern[cnt_win]; // rates 0,1 hold
	assign cnt_bit = cnt_win[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			step_out <= '{slot: SLOT_IDLE, rate: '0, step: 1'b0, sum_up: 1'b0};
		end else if (clk_en) begin
			step_out.slot   <= slot_q;
			step_out.rate   <= rate_q;
			step_out.step   <= step;
			step_out.sum_up <= cnt_win[0] != cnt_last;
		end
	end

endmodule

`default_nettype wire

//--- src/eg_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eg_params.svh"

// envelope generator, 24 slots in time multiplex
module eg_top import eg_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             clk_en,
	input  logic             zero,
	input  eg_cfg_t          cfg,
	output logic [`EG_W-1:0] eg_out
);

	localparam int STAGES    = 5; // phase 1, rate 2, level 2
	localparam int REC_DEPTH = `EG_SLOTS - STAGES;
	localparam eg_rec_t REC_IDLE = '{phase: ph_release, level: `EG_MAX};

	logic [`EG_CNT_W-1:0] eg_cnt;
	logic                 keyon_last;
	logic                 cnt_bit;
	logic                 cnt_last;
	eg_slot_t             slot;
	eg_step_t             step;
	eg_phase_e            next_phase;
	logic [`EG_W-1:0]     next_level;
	eg_rec_t              rec_in;
	eg_rec_t              rec_out;

	assign rec_in.phase = next_phase;
	assign rec_in.level = next_level;

	eg_counter eg_counter_i (
		.clk, .rst, .clk_en, .zero,
		.eg_cnt
	);

	eg_phase eg_phase_i (
		.clk, .rst, .clk_en, .cfg,
		.keyon_last,
		.prev_phase (rec_out.phase),
		.prev_level (rec_out.level),
		.slot
	);

	eg_rate eg_rate_i (
		.clk, .rst, .clk_en, .slot, .eg_cnt, .cnt_last,
		.step_out (step),
		.cnt_bit
	);

	eg_level eg_level_i (
		.clk, .rst, .clk_en,
		.step_in (step),
		.next_phase, .next_level, .eg_out
	);

	////////////////////////////////////////////////////////////////////////////
	// per slot memory, back to the same slot one round later

	slot_delay #(.depth(REC_DEPTH), .payload_t(eg_rec_t), .RST_VAL(REC_IDLE)) rec_dly_i (
		.clk, .rst, .clk_en, .din(rec_in), .dout(rec_out)
	);

	slot_delay #(.depth(`EG_SLOTS), .payload_t(logic), .RST_VAL(1'b0)) keyon_dly_i (
		.clk, .rst, .clk_en, .din(cfg.keyon), .dout(keyon_last)
	);

	slot_delay #(.depth(`EG_SLOTS), .payload_t(logic), .RST_VAL(1'b0)) cnt_dly_i (
		.clk, .rst, .clk_en, .din(cnt_bit), .dout(cnt_last)
	);

endmodule

`default_nettype wire

//--- src/slot_delay.sv
`timescale 1ns/1ps
`default_nettype none

// recirculating shift register, one tap per enabled cycle
module slot_delay #(
	parameter int depth = 24,
	parameter type payload_t = logic,
	parameter payload_t RST_VAL = '0
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     clk_en,
	input  payload_t din,
	output payload_t dout
);

	payload_t taps [depth];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < depth; i++) taps[i] <= RST_VAL;
		end else if (clk_en) begin
			taps[0] <= din;
			for (int i = 1; i < depth; i++) taps[i] <= taps[i-1]; // shift along
		end
	end

	assign dout = taps[depth-1]; // oldest entry

endmodule

`default_nettype wire

//--- tb/eg_patterns.txt
// arate rate1 rate2 rrate d1l ks keycode tl keyon rounds kind expected, all hex
// kind 0 none, 1 exact, 2 top five bits, 3 rising to expected, 4 keep, 5 at least kept
// silent after reset
00 00 00 0 0 0 00 00 0 002 1 3ff
// instant attack, level 0 plus tl x 8
1f 00 00 0 0 0 00 20 1 004 1 100
1f 00 00 0 0 0 00 7f 1 003 1 3f8
1f 00 00 0 0 0 00 00 1 003 1 000
// key off, fast release up to silence
1f 00 00 f 0 0 00 00 0 1a4 3 3ff
// normal attack, first decay stops at d1l 8
18 1f 00 f 8 0 00 00 1 1f4 2 008
// short key off
18 1f 00 f 8 0 00 00 0 002 0 000
// attack again, d1l 15 decays to the bottom step
18 1f 00 f f 0 00 00 1 2bc 2 01f
// key off, then instant attack back to 0
18 1f 00 f f 0 00 00 0 003 0 000
1f 00 00 1 0 0 00 00 1 003 1 000
// slow release with ks 0, keycode 31
1f 00 00 1 0 0 1f 00 0 0f0 4 000
// back to 0
1f 00 00 1 0 0 00 00 1 003 1 000
// same release with ks 3
1f 00 00 1 0 3 1f 00 0 0f0 5 000

//--- tb/eg_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "eg_params.svh"

module eg_tb import eg_pkg::*; ();

	localparam int CLK_HALF  = 10;           // 20 ns period
	localparam int REC_WORDS = 12;           // words per pattern line
	localparam int PAT_RECS  = 32;
	localparam logic [31:0] SEED = 32'd42544;

	// check kinds as coded in column 11 of the pattern file
	localparam int K_EXACT   = 1;
	localparam int K_TOP5    = 2;
	localparam int K_RISE    = 3;            // non-decreasing per slot and ending at expected
	localparam int K_KEEP    = 4;            // remember highest final level
	localparam int K_ATLEAST = 5;            // lowest final level vs remembered one

	logic             clk;
	logic             rst;
	logic             clk_en;
	logic             zero;
	eg_cfg_t          cfg;
	logic [`EG_W-1:0] eg_out;

	logic [15:0]      pat [REC_WORDS*PAT_RECS];
	logic [`EG_W-1:0] last_seen [`EG_SLOTS]; // previous sample per slot position
	logic [`EG_W-1:0] kept;
	logic [31:0]      rng;
	int               errors;
	int               checks;
	int               slot_pos;  // enabled cycles since zero
	int               out_pos;   // output slot position
	int               n_recs;
	int               sum_rounds;
	longint           limit_ns;
	bit               loaded;

	eg_top eg_top_i (
		.clk, .rst, .clk_en, .zero, .cfg,
		.eg_out
	);

	always #CLK_HALF clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// new inputs for the coming edge with about 3 in 4 enabled
	task automatic drive_cycle(input eg_cfg_t c);
		rng    = xorshift32(rng);
		clk_en = (rng[1:0] != 2'b00);
		zero   = clk_en && (slot_pos == 0); // slot 0 marker
		cfg    = c;
		if (clk_en)
			slot_pos = (slot_pos + 1) % `EG_SLOTS;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one pattern line gives the same cfg to every slot for a number of rounds

	task automatic run_phase(input int idx);
		eg_cfg_t          c;
		int               b;
		int               rounds;
		int               kind;
		int               total;
		int               n;
		int               p;
		logic [`EG_W-1:0] expv;
		logic [`EG_W-1:0] lo;
		logic [`EG_W-1:0] hi;
		b         = idx * REC_WORDS;
		c         = '0;
		c.arate   = pat[b][4:0];
		c.rate1   = pat[b+1][4:0];
		c.rate2   = pat[b+2][4:0];
		c.rrate   = pat[b+3][3:0];
		c.d1l     = pat[b+4][3:0];
		c.ks      = pat[b+5][1:0];
		c.keycode = pat[b+6][4:0];
		c.tl      = pat[b+7][6:0];
		c.keyon   = pat[b+8][0];
		rounds    = int'(pat[b+9]);
		kind      = int'(pat[b+10]);
		expv      = pat[b+11][`EG_W-1:0];
		total     = rounds * `EG_SLOTS;
		n         = 0;
		lo        = '1;
		hi        = '0;
		for (int i = 0; i < `EG_SLOTS; i++)
			last_seen[i] = '0;
		while (n < total) begin
			drive_cycle(c);
			@(posedge clk);
			#1;
			if (clk_en) begin // fresh output from this edge
				p       = out_pos;
				out_pos = (out_pos + 1) % `EG_SLOTS;
				if (kind == K_RISE) begin
					checks++;
					if (eg_out < last_seen[p]) begin
						errors++;
						$display("[FAIL] t=%0t eg_out at slot position %0d got %h after %h",
							$time, p, eg_out, last_seen[p]);
					end
					last_seen[p] = eg_out;
				end
				if (n >= total - `EG_SLOTS) begin // last round of the line
					case (kind)
						K_EXACT, K_RISE: check_value("eg_out", 32'(eg_out), 32'(expv));
						K_TOP5: check_value("eg_out[9:5]", 32'(eg_out[`EG_W-1:`EG_W-5]),
							32'(expv));
						default: ;
					endcase
					if (eg_out < lo)
						lo = eg_out;
					if (eg_out > hi)
						hi = eg_out;
				end
				n++;
			end
		end
		if (kind == K_KEEP)
			kept = hi;
		if (kind == K_ATLEAST) begin
			checks++;
			if (lo < kept) begin
				errors++;
				$display("[FAIL] t=%0t eg_out of line %0d got %h below kept level %h",
					$time, idx, lo, kept);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		clk_en     = 1'b0;
		zero       = 1'b0;
		cfg        = '0;
		rng        = SEED;
		errors     = 0;
		checks     = 0;
		slot_pos   = 0;
		out_pos    = 0;
		kept       = '0;
		n_recs     = 0;
		sum_rounds = 0;
		for (int i = 0; i < REC_WORDS * PAT_RECS; i++)
			pat[i] = '0;
		$readmemh("tb/eg_patterns.txt", pat);
		// zero rounds ends the list
		while (n_recs < PAT_RECS && pat[n_recs*REC_WORDS+9] != 16'h0) begin
			sum_rounds += int'(pat[n_recs*REC_WORDS+9]);
			n_recs++;
		end
		if (n_recs == 0) begin
			errors++;
			$display("no pattern lines found in tb/eg_patterns.txt");
		end
		limit_ns = longint'(sum_rounds) * `EG_SLOTS * 4 * 2 * CLK_HALF + 10000;
		loaded   = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		check_value("eg_out", 32'(eg_out), 32'(`EG_MAX)); // silent straight out of reset
		for (int r = 0; r < n_recs; r++)
			run_phase(r);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// watchdog allows about 4 clocks per enabled cycle of all pattern lines
	initial begin
		wait (loaded);
		#(limit_ns);
		$display("watchdog expired at %0t, the pattern run did not complete", $time);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/eg_pkg.sv
src/slot_delay.sv
src/eg_counter.sv
src/eg_phase.sv
src/eg_rate.sv
src/eg_level.sv
src/eg_top.sv
tb/eg_tb.sv
